// File: source/fir_config.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one configuration per compile; FIR_LANES must be a power of two and
// FIR_LANE_BITS its log2, FIR_ACC_WIDTH sized for no overflow at full scale
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// taps, also samples per input block
`define FIR_LANES 8
`define FIR_LANE_BITS 3

// signed operand widths
`define FIR_WORD_WIDTH 18
`define FIR_COEF_WIDTH 18
`define FIR_ACC_WIDTH 39

`endif

// File: source/fir_data_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample and coefficient types; lane order of a block depends on its use
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fir_config.svh"

package fir_data_pkg;

    typedef logic signed [`FIR_WORD_WIDTH-1:0] sample_t;
    typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;

    // full precision filter result
    typedef logic signed [`FIR_ACC_WIDTH-1:0] acc_t;

    // input block: lane 0 oldest
    // read window: lane 0 newest
    typedef sample_t [`FIR_LANES-1:0] sample_block_t;

    // one tap written per cycle
    typedef struct packed {
        logic                       en;
        logic [`FIR_LANE_BITS-1:0]  index;
        coef_t                      value;
    } coef_wr_t;

endpackage

// File: source/fir_ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// window control encodings and sequencer status
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fir_ctrl_pkg;

    // operation applied to the window on the next edge
    typedef enum logic [1:0] {
        OP_HOLD       = 2'b00,
        OP_SHIFT      = 2'b01,
        OP_LOAD       = 2'b10,
        OP_LOAD_SHIFT = 2'b11
    } window_op_e;

    typedef enum logic {
        SEQ_EMPTY = 1'b0,
        SEQ_DRAIN = 1'b1
    } seq_state_e;

    // overrun is sticky until reset
    typedef struct packed {
        logic ready;
        logic overrun;
    } seq_status_t;

endpackage

// File: source/window_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strobes arriving while ready is low are dropped and flagged as overrun;
// there is no handshake back to the source beyond the ready level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "fir_config.svh"

module window_sequencer
    import fir_ctrl_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        block_valid,
    output window_op_e  op,
    output seq_status_t status
);

    typedef logic [`FIR_LANE_BITS:0] count_t;

    seq_state_e state;
    seq_state_e state_next;
    count_t     words_left;
    count_t     words_left_next;
    logic       ready;
    logic       accept;
    logic       overrun;

    // empty, or last old word goes out together with the new load
    assign ready  = (state == SEQ_EMPTY) || (words_left == count_t'(1));
    assign accept = block_valid && ready;

    always_comb begin
        op              = OP_HOLD;
        state_next      = state;
        words_left_next = words_left;
        case (state)
            SEQ_EMPTY: begin
                if (accept) begin
                    op              = OP_LOAD;
                    state_next      = SEQ_DRAIN;
                    words_left_next = count_t'(`FIR_LANES);
                end
            end
            SEQ_DRAIN: begin
                if (accept) begin
                    // refill without a gap in the shift stream
                    op              = OP_LOAD_SHIFT;
                    words_left_next = count_t'(`FIR_LANES);
                end else begin
                    op              = OP_SHIFT;
                    words_left_next = words_left - count_t'(1);
                    if (words_left == count_t'(1)) begin
                        state_next = SEQ_EMPTY;
                    end
                end
            end
            default: begin
                state_next = SEQ_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= SEQ_EMPTY;
            words_left <= '0;
            overrun    <= 1'b0;
        end else begin
            state      <= state_next;
            words_left <= words_left_next;
            if (block_valid && !ready) begin
                overrun <= 1'b1;
            end
        end
    end

    assign status = '{ready: ready, overrun: overrun};

endmodule

// File: source/sliding_window.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcodes are executed unchecked; the sequencer keeps them legal
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "fir_config.svh"

module sliding_window
    import fir_data_pkg::*;
    import fir_ctrl_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  window_op_e    op,
    input  sample_block_t block,
    output sample_block_t window,
    output logic          window_valid
);

    // write window: lane 0 is the next word to leave
    sample_block_t write_win;
    // read window: lane 0 is the newest word
    sample_block_t read_win;
    logic          shifting;

    assign shifting = (op == OP_SHIFT) || (op == OP_LOAD_SHIFT);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            write_win    <= '0;
            read_win     <= '0;
            window_valid <= 1'b0;
        end else begin
            window_valid <= shifting;
            case (op)
                OP_HOLD: begin
                    write_win <= write_win;
                end
                OP_SHIFT: begin
                    // drain towards lane 0, top refills with zero
                    write_win <= {sample_t'(0), write_win[`FIR_LANES-1:1]};
                end
                OP_LOAD: begin
                    write_win <= block;
                end
                OP_LOAD_SHIFT: begin
                    // last old word leaves on the same edge
                    write_win <= block;
                end
                default: begin
                    write_win <= write_win;
                end
            endcase

            // oldest unshifted word becomes the newest sample
            if (shifting) begin
                read_win <= {read_win[`FIR_LANES-2:0], write_win[0]};
            end
        end
    end

    assign window = read_win;

endmodule

// File: source/tap_dot_product.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two register stages, no stall; a tap write affects products from the
// next edge on, so results already in flight keep the old taps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "fir_config.svh"

module tap_dot_product
    import fir_data_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  coef_wr_t      coef_wr,
    input  sample_block_t window,
    input  logic          window_valid,
    output acc_t          y,
    output logic          y_valid
);

    typedef logic signed [`FIR_WORD_WIDTH+`FIR_COEF_WIDTH-1:0] product_t;

    coef_t    coef_bank [`FIR_LANES];
    product_t products  [`FIR_LANES];
    logic     prod_valid;

    // heap ordered tree, leaves at the top half, root at 0
    acc_t     node [2*`FIR_LANES-1];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `FIR_LANES; k++) begin
                coef_bank[k] <= '0;
            end
        end else if (coef_wr.en) begin
            coef_bank[coef_wr.index] <= coef_wr.value;
        end
    end

    // stage one: lane k against tap k
    always_ff @(posedge clock) begin
        if (window_valid) begin
            for (int k = 0; k < `FIR_LANES; k++) begin
                products[k] <= sample_t'(window[k]) * coef_bank[k];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `FIR_LANES; k++) begin
            node[`FIR_LANES-1+k] = acc_t'(products[k]);
        end
        for (int i = `FIR_LANES-2; i >= 0; i--) begin
            node[i] = node[2*i+1] + node[2*i+2];
        end
    end

    // stage two: tree sum
    always_ff @(posedge clock) begin
        if (prod_valid) begin
            y <= node[0];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            y_valid    <= 1'b0;
        end else begin
            prod_valid <= window_valid;
            y_valid    <= prod_valid;
        end
    end

endmodule

// File: source/simd_fir_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one result per shift, two edges after it; output cannot be stalled
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module simd_fir_top
    import fir_data_pkg::*;
    import fir_ctrl_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  logic          block_valid,
    input  sample_block_t block,
    input  coef_wr_t      coef_wr,
    output seq_status_t   status,
    output acc_t          y,
    output logic          y_valid
);

    window_op_e    op;
    sample_block_t window;
    logic          window_valid;

    window_sequencer seq0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .block_valid (block_valid),
        .op          (op),
        .status      (status)
    );

    sliding_window win0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .op           (op),
        .block        (block),
        .window       (window),
        .window_valid (window_valid)
    );

    tap_dot_product dot0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .coef_wr      (coef_wr),
        .window       (window),
        .window_valid (window_valid),
        .y            (y),
        .y_valid      (y_valid)
    );

endmodule

// File: bench/simd_fir_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer rules checked on every edge outside reset, bound into every
// window_sequencer instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "fir_config.svh"

module simd_fir_chk
    import fir_ctrl_pkg::*;
(
    input logic                     clock,
    input logic                     arst_n,
    input window_op_e               op,
    input seq_status_t              status,
    input seq_state_e               state,
    input logic [`FIR_LANE_BITS:0]  words_left
);

    logic loads;
    logic shifts;

    assign loads  = (op == OP_LOAD) || (op == OP_LOAD_SHIFT);
    assign shifts = (op == OP_SHIFT) || (op == OP_LOAD_SHIFT);

    // a load only refills an empty or nearly empty window
    load_when_low: assert property (
        @(posedge clock) disable iff (!arst_n)
        loads |-> (words_left <= 1)
    ) else $error("window load with more than one word left");

    overrun_sticky: assert property (
        @(posedge clock) disable iff (!arst_n)
        status.overrun |=> status.overrun
    ) else $error("overrun cleared without reset");

    // empty or one word left, judged from the count alone
    ready_rule: assert property (
        @(posedge clock) disable iff (!arst_n)
        status.ready == (words_left <= 1)
    ) else $error("ready does not follow the window fill level");

    // nothing to shift out of an empty window
    shift_in_drain: assert property (
        @(posedge clock) disable iff (!arst_n)
        shifts |-> (state == SEQ_DRAIN) && (words_left != 0)
    ) else $error("shift issued outside the drain state");

endmodule

bind window_sequencer simd_fir_chk chk0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .op         (op),
    .status     (status),
    .state      (state),
    .words_left (words_left)
);

// File: bench/simd_fir_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inputs change on rising edges, outputs are checked on falling edges;
// ready is predicted by a model of the acceptance rule and compared
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "fir_config.svh"

module simd_fir_tb
    import fir_data_pkg::*;
    import fir_ctrl_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STREAM_BLOCKS  = 6;

    logic          clock;
    logic          arst_n;
    logic          block_valid;
    sample_block_t block;
    coef_wr_t      coef_wr;
    seq_status_t   status;
    acc_t          y;
    logic          y_valid;

    // sequencer as seen from outside, 0 means empty
    int            words_left_model;
    logic          overrun_model;
    logic          strobe_now;
    sample_block_t block_now;

    coef_t         coef_model [`FIR_LANES];
    // index 0 is the newest sample
    sample_t       history    [`FIR_LANES];
    sample_t       pending_q  [$];
    acc_t          captured_q [$];
    int            run_len;
    int            max_run;

    simd_fir_top dut0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .block_valid (block_valid),
        .block       (block),
        .coef_wr     (coef_wr),
        .status      (status),
        .y           (y),
        .y_valid     (y_valid)
    );

    always #50 clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_result(input acc_t got, input acc_t expected);
        if (got !== expected) begin
            fail_run($sformatf("[FAIL] y: got 0x%h expected 0x%h", got, expected));
        end
    endtask

    task automatic check_status(input seq_status_t got, input seq_status_t expected);
        if (got !== expected) begin
            fail_run($sformatf("[FAIL] status: got 0x%h expected 0x%h", got, expected));
        end
    endtask

    // y[n] = sum of c[k] * x[n-k]
    function automatic acc_t filter_reference(input sample_t x);
        longint sum;
        for (int k = `FIR_LANES - 1; k > 0; k--) begin
            history[k] = history[k-1];
        end
        history[0] = x;
        sum = 0;
        for (int k = 0; k < `FIR_LANES; k++) begin
            sum += longint'(history[k]) * longint'(coef_model[k]);
        end
        return acc_t'(sum);
    endfunction

    function automatic sample_block_t random_block();
        sample_block_t b;
        for (int j = 0; j < `FIR_LANES; j++) begin
            b[j] = sample_t'($urandom);
        end
        return b;
    endfunction

    // one edge; the model follows the strobe of the cycle that ends
    task automatic next_edge();
        @(posedge clock);
        if (strobe_now && words_left_model <= 1) begin
            for (int j = 0; j < `FIR_LANES; j++) begin
                pending_q.push_back(block_now[j]);
            end
            words_left_model = `FIR_LANES;
        end else begin
            if (strobe_now) begin
                overrun_model = 1'b1;
            end
            if (words_left_model > 0) begin
                words_left_model--;
            end
        end
        strobe_now  = 1'b0;
        block_valid <= 1'b0;
        coef_wr     <= '0;
    endtask

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            next_edge();
        end
    endtask

    // strobe in the first cycle where ready is due
    task automatic send_block(input sample_block_t b);
        int waited;
        waited = 0;
        next_edge();
        while (words_left_model > 1) begin
            if (waited >= TIMEOUT_CYCLES) begin
                fail_run("timed out waiting for ready before sending a block");
            end else begin
                next_edge();
                waited++;
            end
        end
        block_valid <= 1'b1;
        block       <= b;
        strobe_now  = 1'b1;
        block_now   = b;
    endtask

    task automatic send_dropped(input sample_block_t b);
        next_edge();
        if (words_left_model <= 1) begin
            fail_run("window was not busy when a dropped strobe was due");
        end else begin
            block_valid <= 1'b1;
            block       <= b;
            strobe_now  = 1'b1;
            block_now   = b;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        next_edge();
        while (pending_q.size() != 0 || words_left_model != 0) begin
            if (waited >= TIMEOUT_CYCLES) begin
                fail_run("timed out waiting for outstanding results");
            end else begin
                next_edge();
                waited++;
            end
        end
    endtask

    task automatic write_coef(input int index, input coef_t value);
        next_edge();
        coef_wr <= '{en: 1'b1, index: index[`FIR_LANE_BITS-1:0], value: value};
        coef_model[index] = value;
    endtask

    task automatic load_random_coefs();
        for (int k = 0; k < `FIR_LANES; k++) begin
            write_coef(k, coef_t'($urandom));
        end
    endtask

    always @(negedge clock) begin : compare_results
        acc_t        expected;
        seq_status_t expected_status;
        if (arst_n) begin
            expected_status.ready   = (words_left_model <= 1);
            expected_status.overrun = overrun_model;
            check_status(status, expected_status);
            if (y_valid) begin
                run_len++;
                if (run_len > max_run) begin
                    max_run = run_len;
                end
                if (pending_q.size() == 0) begin
                    fail_run("y_valid seen with no accepted sample outstanding");
                end else begin
                    expected = filter_reference(pending_q.pop_front());
                    check_result(y, expected);
                    captured_q.push_back(y);
                end
            end else begin
                run_len = 0;
            end
        end
    end

    initial begin : main_sequence
        sample_block_t impulse;
        void'($urandom(33544));
        clock            = 1'b0;
        arst_n           = 1'b0;
        block_valid      = 1'b0;
        block            = '0;
        coef_wr          = '0;
        words_left_model = 0;
        overrun_model    = 1'b0;
        strobe_now       = 1'b0;
        block_now        = '0;
        run_len          = 0;
        max_run          = 0;
        for (int k = 0; k < `FIR_LANES; k++) begin
            coef_model[k] = '0;
            history[k]    = '0;
        end
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;

        // quiet after reset
        idle(12);
        check_status(status, '{ready: 1'b1, overrun: 1'b0});
        if (captured_q.size() != 0) begin
            fail_run("results appeared while the filter was idle");
        end

        // impulse gives back the taps in order
        load_random_coefs();
        impulse    = '0;
        impulse[0] = sample_t'(1);
        send_block(impulse);
        wait_drained();
        if (captured_q.size() != `FIR_LANES) begin
            fail_run("impulse did not give one result per tap");
        end
        for (int k = 0; k < `FIR_LANES; k++) begin
            check_result(captured_q[k], acc_t'(coef_model[k]));
        end

        // back to back blocks, no gap allowed in y_valid
        max_run = 0;
        for (int i = 0; i < STREAM_BLOCKS; i++) begin
            send_block(random_block());
        end
        wait_drained();
        if (max_run < STREAM_BLOCKS * `FIR_LANES) begin
            fail_run("y_valid had a gap during the back to back stream");
        end

        // history must survive idle stretches
        for (int i = 0; i < 6; i++) begin
            send_block(random_block());
            idle($urandom_range(20, 0));
        end
        wait_drained();

        // dropped strobe never reaches the reference
        send_block(random_block());
        send_dropped(random_block());
        send_block(random_block());
        send_block(random_block());
        wait_drained();
        check_status(status, '{ready: 1'b1, overrun: 1'b1});

        // new taps while idle
        load_random_coefs();
        for (int i = 0; i < 4; i++) begin
            send_block(random_block());
        end
        wait_drained();
        idle(4);

        $display("Everything OK");
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/fir_data_pkg.sv
source/fir_ctrl_pkg.sv
source/window_sequencer.sv
source/sliding_window.sv
source/tap_dot_product.sv
source/simd_fir_top.sv
bench/simd_fir_chk.sv
bench/simd_fir_tb.sv

// File: Bender.yml
package:
  name: simd_fir

sources:
  - include_dirs:
      - source
    files:
      - source/fir_data_pkg.sv
      - source/fir_ctrl_pkg.sv
      - source/window_sequencer.sv
      - source/sliding_window.sv
      - source/tap_dot_product.sv
      - source/simd_fir_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/simd_fir_chk.sv
      - bench/simd_fir_tb.sv
